// File: pdu_top.f
logic/pdu_pkg.sv
logic/pdu_inputs.sv
logic/pdu_run_ctrl.sv
logic/pdu_edit.sv
logic/pdu_io_regs.sv
logic/pdu_display.sv
logic/pdu_top.sv
bench/pdu_asserts.sv
bench/pdu_tb.sv

// File: Bender.yml
package:
  name: pdu

sources:
  - logic/pdu_pkg.sv
  - logic/pdu_inputs.sv
  - logic/pdu_run_ctrl.sv
  - logic/pdu_edit.sv
  - logic/pdu_io_regs.sv
  - logic/pdu_display.sv
  - logic/pdu_top.sv
  - target: test
    files:
      - bench/pdu_asserts.sv
      - bench/pdu_tb.sv

// File: bench/pdu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_tb;

    import pdu_pkg::*;

    localparam int SCAN_DIV = 2;
    localparam int FRAME = 8 << SCAN_DIV;           // cycles for all eight digits
    localparam int N_OPS = 200;
    localparam int TIMEOUT_CYCLES = N_OPS * 60 + 1000;  // 60 covers the longest op

    logic       clk_pdu = 1'b0;
    logic       rst;
    logic       step, cont, chk, data, del;
    half_t      x;
    io_addr_t   io_addr;
    word_t      io_dout, chk_pc, chk_data, io_din;
    logic       io_we, io_rd;
    half_t      chk_addr, led;
    logic [7:0] an;
    logic [6:0] seg;
    disp_sel_t  seg_sel;
    logic       run, btn_irq;

    // reference model
    word_t      m_tmp, m_brk, m_swx, m_seg, m_cnt;
    half_t      m_chk, m_led;
    logic       m_vld, m_led_chk;
    disp_sel_t  m_sel;

    int unsigned cycles = 0;
    int unsigned run_seen = 0;
    int unsigned irq_seen = 0;

    // a..g from msb, low = lit
    logic [6:0] seg_table [16] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
        7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
        7'b0000000, 7'b0001100, 7'b0001000, 7'b1100000,
        7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000
    };

    io_addr_t rd_addrs [7] = '{IO_LED, IO_BTN_SW, IO_SEG_RDY, IO_SEG,
                               IO_SWX_VLD, IO_SWX, IO_CNT};

    pdu_top #(.SCAN_DIV_BITS (SCAN_DIV)) u_dut (.*);

    always #5 clk_pdu = ~clk_pdu;

    ////////////////////////////////////////
    // failure, timeout and monitors
    ////////////////////////////////////////
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    always @(posedge clk_pdu) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            stop_with_failure("timeout: the test did not finish in time");
        else if (u_dut.u_asserts.fail_cnt != 0)
            stop_with_failure("a concurrent assertion failed");
    end

    always @(negedge clk_pdu) begin
        if (run)
            run_seen++;
        if (btn_irq)
            irq_seen++;
        chk_data <= data_for(chk_addr);     // memory stand-in
    end

    function automatic word_t data_for(input half_t a);
        return {~a, a ^ 16'h3C5A};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %0t %s got %h expected %h",
                                        $time, name, got, exp));
    endtask

    task automatic check_half(input string name, input half_t got, input half_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %0t %s got %h expected %h",
                                        $time, name, got, exp));
    endtask

    task automatic check_sel(input string name, input disp_sel_t got, input disp_sel_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %0t %s got %b expected %b",
                                        $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %0t %s got %b expected %b",
                                        $time, name, got, exp));
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    task automatic idle(input int n);
        repeat (n) @(negedge clk_pdu);
    endtask

    task automatic set_button(input int which, input logic lvl);
        case (which)
            0: step = lvl;
            1: cont = lvl;
            2: chk  = lvl;
            3: data = lvl;
            default: del = lvl;
        endcase
    endtask

    task automatic press(input int which);
        set_button(which, 1'b1);
        idle(4);
        set_button(which, 1'b0);
        idle(8);
    endtask

    task automatic io_write(input io_addr_t a, input word_t d);
        io_addr = a;
        io_dout = d;
        io_we   = 1'b1;
        idle(1);
        io_we = 1'b0;
        idle(2);
    endtask

    task automatic io_read(input io_addr_t a, output word_t d);
        io_addr = a;
        io_rd   = 1'b1;
        #1 d = io_din;
        idle(1);
        io_rd = 1'b0;
        idle(1);
    endtask

    function automatic word_t read_expect(input io_addr_t a);
        case (a)
            IO_BTN_SW:  return {11'd0, step, cont, chk, data, del, x};
            IO_SEG_RDY: return 32'd1;
            IO_SWX_VLD: return {31'd0, m_vld};
            IO_SWX:     return m_swx;
            IO_CNT:     return m_cnt;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic word_t shown_expect();
        case (m_sel)
            DISP_CPU:  return m_seg;
            DISP_EDIT: return m_tmp;
            default:   return data_for(m_chk);
        endcase
    endfunction

    // decode one full scan frame from an and seg
    task automatic check_display();
        word_t      shown;
        logic [7:0] seen;
        int         d, v, lows;
        shown = '0;
        seen  = '0;
        check_sel("seg_sel", seg_sel, m_sel);
        repeat (FRAME) begin
            d = 0;
            v = -1;
            lows = 0;
            for (int i = 0; i < 8; i++) begin
                if (!an[i]) begin
                    d = i;
                    lows++;
                end
            end
            for (int h = 0; h < 16; h++)
                if (seg_table[h] == seg)
                    v = h;
            if (lows != 1)
                stop_with_failure("display scan did not select exactly one digit");
            if (v < 0)
                stop_with_failure("display shows a segment pattern that is no hex digit");
            shown[d*4 +: 4] = v[3:0];
            seen[d] = 1'b1;
            idle(1);
        end
        if (seen != 8'hFF)
            stop_with_failure("display scan skipped a digit");
        check_word("display", shown, shown_expect());
    endtask

    task automatic wait_for_stop();
        int n;
        n = 0;
        while (run && n < 20) begin
            idle(1);
            n++;
        end
        if (run)
            stop_with_failure("run did not stop at the breakpoint");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int unsigned seen0;
        int          op, k;
        word_t       rd, wd;
        io_addr_t    a;
        void'($urandom(32'h70a8));
        rst = 1'b1;
        {step, cont, chk, data, del} = '0;
        x = '0;
        io_addr = IO_LED;
        io_dout = '0;
        chk_pc = '0;
        chk_data = data_for(16'h0000);
        io_we = 1'b0;
        io_rd = 1'b0;
        {m_tmp, m_brk, m_swx, m_cnt, m_chk} = '0;
        m_led = 16'hFFFF;
        m_seg = 32'h1234_5678;
        m_sel = DISP_CPU;
        m_vld = 1'b0;
        m_led_chk = 1'b0;
        repeat (4) @(posedge clk_pdu);
        @(negedge clk_pdu);
        rst = 1'b0;
        idle(2);

        // state straight after reset
        check_half("led", led, 16'hFFFF);
        check_bit("run", run, 1'b0);
        check_display();
        io_read(IO_SWX_VLD, rd);
        check_word("io_din 0x10", rd, 32'd0);

        repeat (N_OPS) begin
            op = $urandom_range(0, 7);
            case (op)
                0: begin    // switch flip
                    k = $urandom_range(0, 15);
                    x[k] = ~x[k];
                    m_tmp = {m_tmp[27:0], k[3:0]};
                    m_sel = DISP_EDIT;
                    idle(8);
                end
                1: begin
                    m_tmp = m_tmp >> 4;
                    m_sel = DISP_EDIT;
                    press(4);
                end
                2: begin    // submit, second press while valid keeps the word
                    seen0 = irq_seen;
                    if (!m_vld) begin
                        m_swx = m_tmp;
                        m_vld = 1'b1;
                        m_tmp = '0;
                    end
                    press(3);
                    check_word("btn_irq cycles", word_t'(irq_seen - seen0), 32'd1);
                end
                3: begin
                    m_chk = m_tmp[15:0];
                    m_tmp = m_tmp + 32'd1;
                    m_led_chk = 1'b1;
                    m_sel = DISP_CHK;
                    press(2);
                    check_half("chk_addr", chk_addr, m_chk);
                end
                4: begin
                    seen0 = run_seen;
                    press(0);
                    check_word("run cycles after step", word_t'(run_seen - seen0), 32'd1);
                    m_cnt = m_cnt + 32'd1;
                end
                5: begin    // continue up to the breakpoint
                    chk_pc = ~m_tmp;
                    m_brk = m_tmp;
                    m_tmp = '0;
                    seen0 = run_seen;
                    press(1);
                    check_bit("run", run, 1'b1);
                    idle($urandom_range(1, 8));
                    chk_pc = m_brk;
                    wait_for_stop();
                    m_cnt = m_cnt + (run_seen - seen0);
                end
                6: begin
                    k = $urandom_range(0, 2);
                    a = (k == 0) ? IO_LED : (k == 1) ? IO_SEG : IO_CNT;
                    wd = $urandom;
                    io_write(a, wd);
                    if (a == IO_LED) begin
                        m_led = wd[15:0];
                        m_led_chk = 1'b0;
                    end else if (a == IO_SEG) begin
                        m_seg = wd;
                        m_sel = DISP_CPU;
                    end
                end
                default: begin
                    a = rd_addrs[$urandom_range(0, 6)];
                    io_read(a, rd);
                    check_word($sformatf("io_din 0x%h", a), rd, read_expect(a));
                    if (a == IO_SWX)
                        m_vld = 1'b0;
                end
            endcase
            check_half("led", led, m_led_chk ? m_chk : m_led);
            check_bit("run", run, 1'b0);
            if (op != 7)
                check_display();
        end

        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("concurrent assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: bench/pdu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_asserts (
    input logic       clk_pdu,
    input logic       rst,
    input logic [7:0] an,
    input logic       run,
    input logic       step_p,
    input logic       data,
    input logic       btn_irq
);

    int unsigned fail_cnt = 0;  // failures so far

    // one digit lit at a time, moving up by one digit
    a_one_anode: assert property (@(posedge clk_pdu) disable iff (rst)
        $countones(~an) <= 1 &&
        (an == $past(an) || an == {$past(an[6:0]), $past(an[7])}))
        else begin
            fail_cnt++;
            $error("anode scan not a single digit stepping upward");
        end

    a_step_once: assert property (@(posedge clk_pdu) disable iff (rst)
        (step_p && !run) |=> run ##1 !run)
        else begin
            fail_cnt++;
            $error("run after a step was not a single cycle");
        end

    // interrupt follows the synchronized data press, then drops
    a_irq_pulse: assert property (@(posedge clk_pdu) disable iff (rst)
        btn_irq |-> ($past(data, 2) && !$past(data, 3)) ##1 !btn_irq)
        else begin
            fail_cnt++;
            $error("btn_irq not a single pulse on the data press");
        end

endmodule

bind pdu_top pdu_asserts u_asserts (
    .clk_pdu (clk_pdu), .rst (rst), .an (an), .run (run),
    .step_p (step_p), .data (data), .btn_irq (btn_irq)
);

`default_nettype wire

// File: logic/pdu_top.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_top #(
    parameter int unsigned SCAN_DIV_BITS = 12
) (
    input  logic               clk_pdu,
    input  logic               rst,
    input  logic               step,
    input  logic               cont,
    input  logic               chk,
    input  logic               data,
    input  logic               del,
    input  pdu_pkg::half_t     x,
    input  pdu_pkg::io_addr_t  io_addr,
    input  pdu_pkg::word_t     io_dout,
    input  pdu_pkg::word_t     chk_pc,
    input  pdu_pkg::word_t     chk_data,
    input  logic               io_we,
    input  logic               io_rd,
    output pdu_pkg::word_t     io_din,
    output pdu_pkg::half_t     chk_addr,
    output pdu_pkg::half_t     led,
    output logic [7:0]         an,
    output logic [6:0]         seg,
    output pdu_pkg::disp_sel_t seg_sel,
    output logic               run,
    output logic               btn_irq
);

    import pdu_pkg::*;

    // panel pulses
    logic        step_p, cont_p, chk_p, data_p, del_p, x_p;
    nibble_t     x_digit;
    logic [20:0] btn_sw;

    word_t       tmp, brk_addr, swx_data, seg_data;
    half_t       led_data;
    logic        swx_vld, swx_rd;
    logic        led_wr, seg_wr;

    assign btn_irq = data_p;    // submit doubles as interrupt

    pdu_inputs u_inputs (
        .clk_pdu (clk_pdu), .rst (rst),
        .step (step), .cont (cont), .chk (chk), .data (data), .del (del),
        .x (x),
        .step_p (step_p), .cont_p (cont_p), .chk_p (chk_p),
        .data_p (data_p), .del_p (del_p), .x_p (x_p),
        .x_digit (x_digit), .btn_sw (btn_sw)
    );

    pdu_run_ctrl u_run_ctrl (
        .clk_pdu (clk_pdu), .rst (rst),
        .step_p (step_p), .cont_p (cont_p),
        .chk_pc (chk_pc), .brk_addr (brk_addr),
        .run (run)
    );

    pdu_edit u_edit (
        .clk_pdu (clk_pdu), .rst (rst),
        .x_p (x_p), .del_p (del_p), .cont_p (cont_p), .chk_p (chk_p),
        .data_p (data_p), .run (run), .swx_rd (swx_rd), .x_digit (x_digit),
        .tmp (tmp), .brk_addr (brk_addr), .swx_data (swx_data),
        .chk_addr (chk_addr), .swx_vld (swx_vld)
    );

    pdu_io_regs u_io_regs (
        .clk_pdu (clk_pdu), .rst (rst),
        .io_we (io_we), .io_rd (io_rd), .run (run), .swx_vld (swx_vld),
        .io_addr (io_addr), .io_dout (io_dout), .swx_data (swx_data),
        .btn_sw (btn_sw),
        .io_din (io_din), .seg_data (seg_data), .led_data (led_data),
        .led_wr (led_wr), .seg_wr (seg_wr), .swx_rd (swx_rd)
    );

    pdu_display #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_display (
        .clk_pdu (clk_pdu), .rst (rst),
        .led_wr (led_wr), .seg_wr (seg_wr), .x_p (x_p), .del_p (del_p),
        .chk_p (chk_p), .run (run),
        .led_data (led_data), .chk_addr (chk_addr),
        .seg_data (seg_data), .tmp (tmp), .chk_data (chk_data),
        .led (led), .an (an), .seg (seg), .seg_sel (seg_sel)
    );

endmodule

`default_nettype wire

// File: logic/pdu_display.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_display #(
    parameter int unsigned SCAN_DIV_BITS = 12
) (
    input  logic               clk_pdu,
    input  logic               rst,
    input  logic               led_wr,
    input  logic               seg_wr,
    input  logic               x_p,
    input  logic               del_p,
    input  logic               chk_p,
    input  logic               run,
    input  pdu_pkg::half_t     led_data,
    input  pdu_pkg::half_t     chk_addr,
    input  pdu_pkg::word_t     seg_data,
    input  pdu_pkg::word_t     tmp,
    input  pdu_pkg::word_t     chk_data,
    output pdu_pkg::half_t     led,
    output logic [7:0]         an,
    output logic [6:0]         seg,
    output pdu_pkg::disp_sel_t seg_sel
);

    import pdu_pkg::*;

    localparam int CNT_W = SCAN_DIV_BITS + 3;

    logic             led_sel;      // 1 shows chk_addr
    logic [CNT_W-1:0] scan_cnt;
    logic [2:0]       digit;
    word_t            disp_word;
    nibble_t          hex;

    ////////////////////////////////////////
    // source selects
    ////////////////////////////////////////
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst)
            led_sel <= 1'b0;
        else if (led_wr)
            led_sel <= 1'b0;
        else if (chk_p)
            led_sel <= 1'b1;
    end

    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst)
            seg_sel <= DISP_CPU;
        else if (seg_wr)
            seg_sel <= DISP_CPU;
        else if (x_p || del_p)
            seg_sel <= DISP_EDIT;       // follow the edit word
        else if (chk_p && !run)
            seg_sel <= DISP_CHK;
    end

    assign led = led_sel ? chk_addr : led_data;

    always_comb begin
        case (seg_sel)
            DISP_CPU:  disp_word = seg_data;
            DISP_EDIT: disp_word = tmp;
            DISP_CHK:  disp_word = chk_data;
            default:   disp_word = tmp;
        endcase
    end

    ////////////////////////////////////////
    // digit scan
    ////////////////////////////////////////
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    assign digit = scan_cnt[CNT_W-1 -: 3];
    assign an    = ~(8'b1 << digit);            // active low anode
    assign hex   = disp_word[{digit, 2'b00} +: 4];

    // segments a..g from msb, low = lit
    always_comb begin
        case (hex)
            4'h0: seg = 7'b0000001;
            4'h1: seg = 7'b1001111;
            4'h2: seg = 7'b0010010;
            4'h3: seg = 7'b0000110;
            4'h4: seg = 7'b1001100;
            4'h5: seg = 7'b0100100;
            4'h6: seg = 7'b0100000;
            4'h7: seg = 7'b0001111;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0001100;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b1100000;
            4'hC: seg = 7'b0110001;
            4'hD: seg = 7'b1000010;
            4'hE: seg = 7'b0110000;
            default: seg = 7'b0111000;  // F
        endcase
    end

endmodule

`default_nettype wire

// File: logic/pdu_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_io_regs (
    input  logic              clk_pdu,
    input  logic              rst,
    input  logic              io_we,
    input  logic              io_rd,
    input  logic              run,
    input  logic              swx_vld,
    input  pdu_pkg::io_addr_t io_addr,
    input  pdu_pkg::word_t    io_dout,
    input  pdu_pkg::word_t    swx_data,
    input  logic [20:0]       btn_sw,
    output pdu_pkg::word_t    io_din,
    output pdu_pkg::word_t    seg_data,
    output pdu_pkg::half_t    led_data,
    output logic              led_wr,
    output logic              seg_wr,
    output logic              swx_rd
);

    import pdu_pkg::*;

    word_t run_cnt;

    assign led_wr = io_we && (io_addr == IO_LED);
    assign seg_wr = io_we && (io_addr == IO_SEG);
    assign swx_rd = io_rd && (io_addr == IO_SWX);

    ////////////////////////////////////////
    // cpu output registers
    ////////////////////////////////////////
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst) begin
            led_data <= LED_RESET;
            seg_data <= SEG_RESET;
        end else begin
            if (led_wr)
                led_data <= io_dout[15:0];
            if (seg_wr)
                seg_data <= io_dout;
        end
    end

    // counts cycles the cpu is enabled
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst)
            run_cnt <= '0;
        else if (run)
            run_cnt <= run_cnt + 32'd1;
    end

    ////////////////////////////////////////
    // cpu read mux
    ////////////////////////////////////////
    always_comb begin
        case (io_addr)
            IO_BTN_SW:
                io_din = {11'd0, btn_sw};
            IO_SEG_RDY:
                io_din = 32'd1;         // display always ready
            IO_SWX_VLD:
                io_din = {31'd0, swx_vld};
            IO_SWX:
                io_din = swx_data;
            IO_CNT:
                io_din = run_cnt;
            default:
                io_din = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/pdu_edit.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_edit (
    input  logic             clk_pdu,
    input  logic             rst,
    input  logic             x_p,
    input  logic             del_p,
    input  logic             cont_p,
    input  logic             chk_p,
    input  logic             data_p,
    input  logic             run,
    input  logic             swx_rd,
    input  pdu_pkg::nibble_t x_digit,
    output pdu_pkg::word_t   tmp,
    output pdu_pkg::word_t   brk_addr,
    output pdu_pkg::word_t   swx_data,
    output pdu_pkg::half_t   chk_addr,
    output logic             swx_vld
);

    logic submit;   // data press with the mailbox empty
    logic set_brk;
    logic set_chk;

    assign submit  = data_p & ~swx_vld;
    assign set_brk = cont_p & ~run;
    assign set_chk = chk_p & ~run;

    ////////////////////////////////////////
    // edit word
    ////////////////////////////////////////
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst)
            tmp <= '0;
        else if (x_p)
            tmp <= {tmp[27:0], x_digit};    // new digit enters low
        else if (del_p)
            tmp <= {4'h0, tmp[31:4]};
        else if (set_brk || submit)
            tmp <= '0;
        else if (set_chk)
            tmp <= tmp + 32'd1;             // walk through memory
    end

    // targets take the word as it was before the clear
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst) begin
            swx_data <= '0;
            brk_addr <= '0;
            chk_addr <= '0;
        end else begin
            if (submit)
                swx_data <= tmp;
            if (set_brk)
                brk_addr <= tmp;
            if (set_chk)
                chk_addr <= tmp[15:0];
        end
    end

    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst)
            swx_vld <= 1'b0;
        else if (submit)
            swx_vld <= 1'b1;
        else if (swx_rd)
            swx_vld <= 1'b0;    // cpu fetched the word
    end

endmodule

`default_nettype wire

// File: logic/pdu_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_run_ctrl (
    input  logic           clk_pdu,
    input  logic           rst,
    input  logic           step_p,
    input  logic           cont_p,
    input  pdu_pkg::word_t chk_pc,
    input  pdu_pkg::word_t brk_addr,
    output logic           run
);

    import pdu_pkg::*;

    run_state_t state, state_nxt;

    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst) begin
            state <= RS_STOP;
            run   <= 1'b0;
        end else begin
            state <= state_nxt;
            run   <= (state_nxt != RS_STOP);   // cpu clock enable
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RS_STOP: begin
                if (step_p)
                    state_nxt = RS_STEP;
                else if (cont_p)
                    state_nxt = RS_RUN;
            end
            RS_STEP:
                state_nxt = RS_STOP;    // one instruction only
            RS_RUN: begin
                // breakpoint hit
                if (chk_pc == brk_addr)
                    state_nxt = RS_STOP;
            end
            default:
                state_nxt = RS_STOP;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/pdu_inputs.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_inputs (
    input  logic             clk_pdu,
    input  logic             rst,
    input  logic             step,
    input  logic             cont,
    input  logic             chk,
    input  logic             data,
    input  logic             del,
    input  pdu_pkg::half_t   x,
    output logic             step_p,
    output logic             cont_p,
    output logic             chk_p,
    output logic             data_p,
    output logic             del_p,
    output logic             x_p,
    output pdu_pkg::nibble_t x_digit,
    output logic [20:0]      btn_sw
);

    import pdu_pkg::*;

    logic [4:0] btn_raw;
    logic [4:0] btn_s1, btn_s2, btn_hist;
    logic [4:0] btn_rise;
    half_t      x_s1, x_s2, x_hist;
    half_t      x_diff;

    assign btn_raw = {step, cont, chk, data, del};

    ////////////////////////////////////////
    // two-flop sync plus history
    ////////////////////////////////////////
    always_ff @(posedge clk_pdu or posedge rst) begin
        if (rst) begin
            btn_s1   <= '0;
            btn_s2   <= '0;
            btn_hist <= '0;
            x_s1     <= '0;
            x_s2     <= '0;
            x_hist   <= '0;
        end else begin
            btn_s1   <= btn_raw;
            btn_s2   <= btn_s1;
            btn_hist <= btn_s2;
            x_s1     <= x;
            x_s2     <= x_s1;
            x_hist   <= x_s2;
        end
    end

    assign btn_rise = btn_s2 & ~btn_hist;   // rising edges only
    assign {step_p, cont_p, chk_p, data_p, del_p} = btn_rise;

    // switches count on any flip, either direction
    assign x_diff = x_s2 ^ x_hist;
    assign x_p    = |x_diff;

    // index of the flipped switch, 0 when several moved at once
    always_comb begin
        x_digit = '0;
        if ((x_diff & (x_diff - 16'd1)) == 16'd0) begin
            for (int i = 0; i < 16; i++) begin
                if (x_diff[i])
                    x_digit = nibble_t'(i);
            end
        end
    end

    assign btn_sw = {btn_s2, x_s2};     // buttons above switches

endmodule

`default_nettype wire

// File: logic/pdu_pkg.sv
`default_nettype none

package pdu_pkg;

    ////////////////////////////////////////
    // data widths
    ////////////////////////////////////////
    typedef logic [31:0] word_t;    // io bus, edit word, pc
    typedef logic [15:0] half_t;    // switches, leds, chk_addr
    typedef logic [3:0]  nibble_t;

    // cpu run mode
    typedef enum logic [1:0] {
        RS_STOP = 2'd0,
        RS_STEP = 2'd1,
        RS_RUN  = 2'd2
    } run_state_t;

    // memory-mapped io addresses
    typedef enum logic [7:0] {
        IO_LED     = 8'h00,
        IO_BTN_SW  = 8'h04,
        IO_SEG_RDY = 8'h08,
        IO_SEG     = 8'h0C,
        IO_SWX_VLD = 8'h10,
        IO_SWX     = 8'h14,
        IO_CNT     = 8'h18
    } io_addr_t;

    // display source, one-hot so it drives the rgb lamp directly
    typedef enum logic [2:0] {
        DISP_CPU  = 3'b001,
        DISP_EDIT = 3'b010,
        DISP_CHK  = 3'b100
    } disp_sel_t;

    localparam half_t LED_RESET = 16'hFFFF;
    localparam word_t SEG_RESET = 32'h1234_5678;

endpackage

`default_nettype wire
